// ==== sim.f ====
hdl/cart_load_pkg.sv
hdl/ines_header_decode.sv
hdl/rom_load_fsm.sv
hdl/mem_write_stage.sv
hdl/cart_status_regs.sv
hdl/cart_loader_top.sv
tb/tb_clock.sv
tb/cart_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module cart_loader_tb -f sim.f -o cart_loader_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/cart_loader_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" sim.log; then
	echo "simulation reported failures"
	exit 1
fi

echo "simulation passed"
exit 0

// ==== tb/cart_loader_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Directed tests for the iNES cartridge loader
// The byte source paces itself on load_wait with one byte in flight
// Image data comes from a fixed-seed xorshift generator
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cart_loader_tb;

localparam int BYTE_TIMEOUT = 16;   // One memory slot plus margin
localparam int DONE_TIMEOUT = 64;

logic                         clk;
logic                         reset_nes;
logic                         downloading;
logic                         byte_valid;
cart_load_pkg::byte_t         byte_data;
logic                         invert_mirroring;
logic                         mem_write;
cart_load_pkg::mem_addr_t     mem_addr;
cart_load_pkg::byte_t         mem_data;
logic                         load_wait;
logic                         busy;
logic                         done;
logic                         error;
cart_load_pkg::mapper_flags_t mapper_flags;
logic                         console_hold;

cart_load_pkg::byte_t         image_hdr [cart_load_pkg::HEADER_BYTES];
cart_load_pkg::mem_addr_t     exp_addr [$];
cart_load_pkg::byte_t         exp_data [$];
cart_load_pkg::mem_addr_t     got_addr [$];
cart_load_pkg::byte_t         got_data [$];
cart_load_pkg::mapper_flags_t good_flags;   // Last flags of a good load
logic [31:0]                  rng_state = 32'hced2003f;
int                           error_count;
int                           check_count;
int                           gap_errors;
int                           start_errors;
string                        test_name;

tb_clock u_clock (.clk(clk), .reset_nes(reset_nes));

cart_loader_top uut (
	.clk(clk), .reset_nes(reset_nes), .downloading(downloading),
	.byte_valid(byte_valid), .byte_data(byte_data), .invert_mirroring(invert_mirroring),
	.mem_write(mem_write), .mem_addr(mem_addr), .mem_data(mem_data),
	.load_wait(load_wait), .busy(busy), .done(done), .error(error),
	.mapper_flags(mapper_flags), .console_hold(console_hold)
);

// Records each memory write on the falling edge
always @(negedge clk) begin
	if (mem_write) begin
		got_addr.push_back(mem_addr);
		got_data.push_back(mem_data);
	end
end

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	return y ^ (y << 5);
endfunction

task automatic check_value(input string what, input logic [31:0] expected,
	input logic [31:0] actual);
	check_count++;
	if (expected !== actual) begin
		error_count++;
		$display("mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
	end
endtask

task automatic report_failure(input string msg);
	error_count++;
	$display("%s: %s", test_name, msg);
endtask

task automatic begin_test(input string name);
	test_name    = name;
	start_errors = error_count;
endtask

task automatic finish_test();
	$display("%s finished with %0d failed checks", test_name, error_count - start_errors);
endtask

// One strobe, then follow a copied byte until it reaches memory
task automatic send_byte(input cart_load_pkg::byte_t value, input logic copied);
	int n;
	n = 0;
	while (load_wait && n < BYTE_TIMEOUT) begin
		@(negedge clk);
		n++;
	end
	if (load_wait) begin
		report_failure("load_wait stayed high, byte not sent");
		return;
	end
	byte_valid = 1'b1;
	byte_data  = value;
	@(negedge clk);
	byte_valid = 1'b0;
	if (copied) begin
		n = 0;
		while (!mem_write && n < BYTE_TIMEOUT) begin
			if (!load_wait)
				gap_errors++;
			@(negedge clk);
			n++;
		end
		if (!load_wait)
			gap_errors++;
		if (!mem_write)
			report_failure("no memory write followed a copied byte");
	end
endtask

task automatic wait_done();
	int n;
	n = 0;
	while (!done && n < DONE_TIMEOUT) begin
		@(negedge clk);
		n++;
	end
	if (!done)
		report_failure("done never rose");
	repeat (2) @(negedge clk);   // Flags latch the cycle after done
endtask

task automatic set_header(input cart_load_pkg::byte_t prg, input cart_load_pkg::byte_t chr,
	input cart_load_pkg::byte_t b6, input cart_load_pkg::byte_t b7);
	for (int i = 0; i < cart_load_pkg::HEADER_BYTES; i++)
		image_hdr[i] = 8'h00;
	image_hdr[0] = 8'h4E;   // "NES" 0x1A
	image_hdr[1] = 8'h45;
	image_hdr[2] = 8'h53;
	image_hdr[3] = 8'h1A;
	image_hdr[4] = prg;
	image_hdr[5] = chr;
	image_hdr[6] = b6;
	image_hdr[7] = b7;
endtask

task automatic load_image(input int prg_pages, input int chr_pages, input logic header_good);
	int                       prg_len;
	cart_load_pkg::mem_addr_t addr;
	prg_len = prg_pages << 14;
	exp_addr.delete();
	exp_data.delete();
	got_addr.delete();
	got_data.delete();
	downloading = 1'b1;
	@(negedge clk);
	for (int i = 0; i < cart_load_pkg::HEADER_BYTES; i++)
		send_byte(image_hdr[i], 1'b0);
	check_value("busy after header", 1, busy);
	repeat (2) @(negedge clk);   // An empty PRG region costs the FSM a cycle
	if (header_good) begin
		for (int i = 0; i < prg_len + (chr_pages << 13); i++) begin
			rng_state = xorshift32(rng_state);
			addr = (i < prg_len) ? 22'(i) : 22'h200000 + 22'(i - prg_len);
			exp_addr.push_back(addr);
			exp_data.push_back(rng_state[7:0]);
			send_byte(rng_state[7:0], 1'b1);
		end
	end else begin
		for (int i = 0; i < 4; i++)
			send_byte(8'hA5, 1'b0);   // Trailing bytes must go nowhere
	end
	wait_done();
	check_value("busy after done", 0, busy);
	downloading = 1'b0;
	@(negedge clk);
endtask

task automatic check_writes();
	check_value("write count", exp_addr.size(), got_addr.size());
	for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
		check_value("write address", exp_addr[i], got_addr[i]);
		check_value("write data", exp_data[i], got_data[i]);
	end
endtask

//////////////////////////////////////////////////////////////////////
// Tests
//////////////////////////////////////////////////////////////////////

task automatic reset_values();
	int n;
	begin_test("reset_values");
	@(negedge clk);
	n = 0;
	while (reset_nes && n < 20) begin
		@(negedge clk);
		n++;
	end
	if (reset_nes)
		report_failure("reset was never released");
	check_value("mem_write", 0, mem_write);
	check_value("load_wait", 0, load_wait);
	check_value("busy", 0, busy);
	check_value("done", 0, done);
	check_value("error", 0, error);
	check_value("console_hold", 0, console_hold);
	finish_test();
endtask

task automatic ines_load();
	cart_load_pkg::mapper_flags_t exp;
	begin_test("ines_load");
	gap_errors = 0;
	set_header(8'd1, 8'd1, 8'h12, 8'h20);   // Mapper 0x21 with battery
	load_image(1, 1, 1'b1);
	check_writes();
	check_value("done", 1, done);
	check_value("error", 0, error);
	exp           = '0;
	exp.mapper    = 8'h21;
	exp.has_saves = 1'b1;
	check_value("flags", exp, mapper_flags);
	check_value("has_chr_ram", 0, mapper_flags.has_chr_ram);
	finish_test();
endtask

task automatic pacing_and_hold();
	int n;
	begin_test("pacing_and_hold");
	check_value("strobe gaps with load_wait low", 0, gap_errors);
	n = 0;
	while (console_hold && n < int'(cart_load_pkg::HOLD_COUNT) + 16) begin
		@(negedge clk);
		n++;
	end
	if (console_hold)
		report_failure("console_hold did not fall after the load");
	finish_test();
endtask

task automatic nes20_flags();
	begin_test("nes20_flags");
	set_header(8'd2, 8'd0, 8'h53, 8'h18);   // NES 2.0 marker in byte 7
	image_hdr[8]     = 8'h32;
	image_hdr[10]    = 8'h07;
	image_hdr[15]    = 8'h19;
	invert_mirroring = 1'b1;
	load_image(2, 0, 1'b1);
	invert_mirroring = 1'b0;
	check_writes();
	check_value("spare", 0, mapper_flags.spare);
	check_value("piano", 1, mapper_flags.piano);
	check_value("prg_ram_shift", 7, mapper_flags.prg_ram_shift);
	check_value("has_saves", 1, mapper_flags.has_saves);
	check_value("submapper", 8'h32, mapper_flags.submapper);
	check_value("four_screen", 0, mapper_flags.four_screen);
	check_value("has_chr_ram", 1, mapper_flags.has_chr_ram);
	check_value("mirroring", 0, mapper_flags.mirroring);
	check_value("chr_size", 0, mapper_flags.chr_size);
	check_value("prg_size", 1, mapper_flags.prg_size);   // 2 pages
	check_value("mapper", 8'h15, mapper_flags.mapper);
	finish_test();
endtask

task automatic dirty_header();
	cart_load_pkg::mapper_flags_t exp;
	begin_test("dirty_header");
	set_header(8'd0, 8'd1, 8'hA9, 8'h40);
	image_hdr[8] = 8'h05;
	for (int i = 10; i < cart_load_pkg::HEADER_BYTES; i++)
		image_hdr[i] = 8'h30 + 8'(i);   // Junk tail like old dumps
	load_image(0, 1, 1'b1);
	check_writes();
	exp             = '0;
	exp.mapper      = 8'h0A;
	exp.four_screen = 1'b1;
	exp.mirroring   = 1'b1;
	check_value("upper mapper nibble", 4'h0, mapper_flags.mapper[7:4]);
	check_value("flags", exp, mapper_flags);
	good_flags = exp;
	finish_test();
endtask

task automatic bad_header();
	begin_test("bad_header");
	for (int k = 0; k < 2; k++) begin
		set_header(8'd1, 8'd0, (k == 0) ? 8'h00 : 8'h04, 8'h00);
		if (k == 0)
			image_hdr[3] = 8'h1B;   // Broken magic
		load_image(1, 0, 1'b0);
		check_value("write count", 0, got_addr.size());
		check_value("done", 1, done);
		check_value("error", 1, error);
		check_value("flags kept", good_flags, mapper_flags);
		repeat (int'(cart_load_pkg::HOLD_COUNT) + 8) @(negedge clk);
		check_value("console_hold", 1, console_hold);
	end
	finish_test();
endtask

initial begin
	downloading      = 1'b0;
	byte_valid       = 1'b0;
	byte_data        = 8'h00;
	invert_mirroring = 1'b0;
	error_count      = 0;
	check_count      = 0;
	gap_errors       = 0;
	good_flags       = '0;
	reset_values();
	ines_load();
	pacing_and_hold();
	nes20_flags();
	dirty_header();
	bad_header();
	$display("checks %0d, failed %0d", check_count, error_count);
	if (error_count == 0)
		$display("No errors");
	else
		$display("Errors found");
	$finish;
end

endmodule

// ==== tb/tb_clock.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench clock with a 40 ns period
// Reset is held for 5 cycles and released on a falling edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_clock
(
	output logic clk,
	output logic reset_nes
);

initial begin
	clk       = 1'b0;
	reset_nes = 1'b1;
	repeat (5) @(posedge clk);
	@(negedge clk);
	reset_nes = 1'b0;
end

always #20 clk = ~clk;

endmodule

// ==== hdl/cart_loader_top.sv ====
//////////////////////////////////////////////////////////////////////
// iNES cartridge loader for the NES core
// byte_valid may only be raised while load_wait is low
// PRG lands at 0 and CHR at 0x200000, the header is not stored
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cart_loader_top
(
	input  logic                         clk,
	input  logic                         reset_nes,
	input  logic                         downloading,
	input  logic                         byte_valid,
	input  cart_load_pkg::byte_t         byte_data,
	input  logic                         invert_mirroring,
	output logic                         mem_write,
	output cart_load_pkg::mem_addr_t     mem_addr,
	output cart_load_pkg::byte_t         mem_data,
	output logic                         load_wait,
	output logic                         busy,
	output logic                         done,
	output logic                         error,
	output cart_load_pkg::mapper_flags_t mapper_flags,
	output logic                         console_hold
);

// Header path
cart_load_pkg::byte_t         header [cart_load_pkg::HEADER_BYTES];
cart_load_pkg::mapper_flags_t dec_flags;
logic                         header_ok;
cart_load_pkg::byte_count_t   prg_bytes;
cart_load_pkg::byte_count_t   chr_bytes;

// Loader write, before pacing
logic                         wr_pulse;
cart_load_pkg::mem_addr_t     wr_addr;
cart_load_pkg::byte_t         wr_data;

ines_header_decode u_decode (
	.header           (header),
	.invert_mirroring (invert_mirroring),
	.flags            (dec_flags),
	.header_ok        (header_ok),
	.prg_bytes        (prg_bytes),
	.chr_bytes        (chr_bytes)
);

rom_load_fsm u_fsm (
	.clk         (clk),
	.reset_nes   (reset_nes),
	.downloading (downloading),
	.byte_valid  (byte_valid),
	.byte_data   (byte_data),
	.header      (header),
	.header_ok   (header_ok),
	.prg_bytes   (prg_bytes),
	.chr_bytes   (chr_bytes),
	.wr_pulse    (wr_pulse),
	.wr_addr     (wr_addr),
	.wr_data     (wr_data),
	.busy        (busy),
	.done        (done),
	.error       (error)
);

mem_write_stage u_stage (
	.clk       (clk),
	.reset_nes (reset_nes),
	.wr_pulse  (wr_pulse),
	.wr_addr   (wr_addr),
	.wr_data   (wr_data),
	.mem_write (mem_write),
	.mem_addr  (mem_addr),
	.mem_data  (mem_data),
	.load_wait (load_wait)
);

cart_status_regs u_status (
	.clk          (clk),
	.reset_nes    (reset_nes),
	.downloading  (downloading),
	.busy         (busy),
	.done         (done),
	.error        (error),
	.flags_in     (dec_flags),
	.mapper_flags (mapper_flags),
	.console_hold (console_hold)
);

endmodule

// ==== hdl/cart_status_regs.sv ====
//////////////////////////////////////////////////////////////////////
// Latched mapper flags and the console hold
// Flags only change after a good load, a failed one keeps the old set
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cart_status_regs
(
	input  logic                         clk,
	input  logic                         reset_nes,
	input  logic                         downloading,
	input  logic                         busy,
	input  logic                         done,
	input  logic                         error,
	input  cart_load_pkg::mapper_flags_t flags_in,
	output cart_load_pkg::mapper_flags_t mapper_flags,
	output logic                         console_hold
);

logic                                       done_q;
logic                                       done_rise;
logic [$bits(cart_load_pkg::HOLD_COUNT)-1:0] hold_cnt;

assign done_rise = done & ~done_q;

always_ff @(posedge clk) begin
	if (reset_nes) begin
		done_q       <= 1'b0;
		mapper_flags <= '0;
	end else begin
		done_q <= done;
		if (done_rise && !error)
			mapper_flags <= flags_in;
	end
end

// Countdown starts once the loader has gone idle
always_ff @(posedge clk) begin
	if (reset_nes)
		hold_cnt <= '0;
	else if (downloading)
		hold_cnt <= cart_load_pkg::HOLD_COUNT;
	else if (!busy && hold_cnt != '0)
		hold_cnt <= hold_cnt - 1'b1;
end

assign console_hold = downloading | error | (hold_cnt != '0);

// The console must never run while the loader is still copying
a_hold_while_busy: assert property (
	@(posedge clk) disable iff (reset_nes) busy |-> console_hold
);

endmodule

// ==== hdl/mem_write_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Paces loader writes to the slow memory slot
// Holds one write only, the source must honour load_wait
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_write_stage
(
	input  logic                     clk,
	input  logic                     reset_nes,
	input  logic                     wr_pulse,
	input  cart_load_pkg::mem_addr_t wr_addr,
	input  cart_load_pkg::byte_t     wr_data,
	output logic                     mem_write,
	output cart_load_pkg::mem_addr_t mem_addr,
	output cart_load_pkg::byte_t     mem_data,
	output logic                     load_wait
);

cart_load_pkg::slot_phase_t phase;        // Slot comes once every 4 clocks
logic                       slot;
logic                       pending;
cart_load_pkg::mem_addr_t   stage_addr;
cart_load_pkg::byte_t       stage_data;

assign slot = phase == cart_load_pkg::SLOT_PHASE;

always_ff @(posedge clk) begin
	if (reset_nes)
		phase <= '0;
	else
		phase <= phase + 1'b1;
end

always_ff @(posedge clk) begin
	if (reset_nes)
		pending <= 1'b0;
	else if (wr_pulse)
		pending <= 1'b1;
	else if (slot)
		pending <= 1'b0;   // Written this cycle
end

// Staging register
always_ff @(posedge clk) begin
	if (wr_pulse) begin
		stage_addr <= wr_addr;
		stage_data <= wr_data;
	end
end

assign mem_write = pending & slot;
assign mem_addr  = stage_addr;
assign mem_data  = stage_data;
assign load_wait = pending;   // Drops the cycle after mem_write

// Byte source must stall until the staged write has gone out
a_no_write_while_waiting: assert property (
	@(posedge clk) disable iff (reset_nes) load_wait |-> !wr_pulse
);

endmodule

// ==== hdl/rom_load_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// Load state machine for one iNES image
// A rising edge of downloading restarts it, even after an error
// Writes are single-cycle pulses and need the stage to pace them
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rom_load_fsm
(
	input  logic                       clk,
	input  logic                       reset_nes,
	input  logic                       downloading,
	input  logic                       byte_valid,
	input  cart_load_pkg::byte_t       byte_data,
	output cart_load_pkg::byte_t       header [cart_load_pkg::HEADER_BYTES],
	input  logic                       header_ok,
	input  cart_load_pkg::byte_count_t prg_bytes,
	input  cart_load_pkg::byte_count_t chr_bytes,
	output logic                       wr_pulse,
	output cart_load_pkg::mem_addr_t   wr_addr,
	output cart_load_pkg::byte_t       wr_data,
	output logic                       busy,
	output logic                       done,
	output logic                       error
);

cart_load_pkg::load_state_t state;
cart_load_pkg::hdr_idx_t    hdr_idx;
cart_load_pkg::hdr_idx_t    hdr_slot;
cart_load_pkg::byte_count_t byte_cnt;   // Bytes left in current region
cart_load_pkg::mem_addr_t   addr;
logic                       downloading_q;
logic                       dl_rise;
logic                       hdr_take;
logic                       in_copy;

assign dl_rise = downloading & ~downloading_q;

// A byte in the restart cycle is header byte 0
assign hdr_take = byte_valid & (dl_rise | (state == cart_load_pkg::S_HEADER));
assign hdr_slot = dl_rise ? '0 : hdr_idx;

assign in_copy = (state == cart_load_pkg::S_PRG) || (state == cart_load_pkg::S_CHR);

// One memory write per byte while a region is open
assign wr_pulse = byte_valid & in_copy & (byte_cnt != '0) & ~dl_rise;
assign wr_addr  = addr;
assign wr_data  = byte_data;

always_ff @(posedge clk) begin
	if (reset_nes)
		downloading_q <= 1'b0;
	else
		downloading_q <= downloading;
end

// Header bytes
always_ff @(posedge clk) begin
	if (hdr_take)
		header[hdr_slot] <= byte_data;
end

//////////////////////////////////////////////////////////////////////
// State and counters
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
	if (reset_nes) begin
		state    <= cart_load_pkg::S_HEADER;
		hdr_idx  <= '0;
		byte_cnt <= '0;
		addr     <= cart_load_pkg::PRG_BASE;
		busy     <= 1'b0;
		done     <= 1'b0;
		error    <= 1'b0;
	end else if (dl_rise) begin
		state   <= cart_load_pkg::S_HEADER;
		busy    <= 1'b0;
		done    <= 1'b0;
		error   <= 1'b0;
		hdr_idx <= '0;
		if (byte_valid)
			hdr_idx <= cart_load_pkg::hdr_idx_t'(1);
	end else begin
		case (state)
			cart_load_pkg::S_HEADER: begin
				if (byte_valid) begin
					hdr_idx <= hdr_idx + 1'b1;
					if (hdr_idx == cart_load_pkg::HDR_LAST) begin
						// Validity and sizes are already known from bytes 0 to 14
						busy     <= 1'b1;
						byte_cnt <= prg_bytes;
						addr     <= cart_load_pkg::PRG_BASE;
						state    <= header_ok ? cart_load_pkg::S_PRG : cart_load_pkg::S_ERROR;
					end
				end
			end
			cart_load_pkg::S_PRG, cart_load_pkg::S_CHR: begin
				if (byte_cnt != '0) begin
					if (byte_valid) begin
						byte_cnt <= byte_cnt - 1'b1;
						addr     <= addr + 1'b1;
					end
				end else if (state == cart_load_pkg::S_PRG) begin
					state    <= cart_load_pkg::S_CHR;
					addr     <= cart_load_pkg::CHR_BASE;
					byte_cnt <= chr_bytes;
				end else begin
					state <= cart_load_pkg::S_DONE;
					done  <= 1'b1;
					busy  <= 1'b0;
				end
			end
			cart_load_pkg::S_ERROR: begin
				state <= cart_load_pkg::S_DONE;
				done  <= 1'b1;
				error <= 1'b1;
				busy  <= 1'b0;
			end
			cart_load_pkg::S_DONE: ;   // Wait here for the next download
			default: state <= cart_load_pkg::S_HEADER;
		endcase
	end
end

endmodule

// ==== hdl/ines_header_decode.sv ====
//////////////////////////////////////////////////////////////////////
// Combinational decode of the 16 captured iNES header bytes
// Byte counts and header_ok only use bytes 0 to 14, flags use all 16
// Trainer images are reported as bad headers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ines_header_decode
(
	input  cart_load_pkg::byte_t         header [cart_load_pkg::HEADER_BYTES],
	input  logic                         invert_mirroring,
	output cart_load_pkg::mapper_flags_t flags,
	output logic                         header_ok,
	output cart_load_pkg::byte_count_t   prg_bytes,
	output cart_load_pkg::byte_count_t   chr_bytes
);

cart_load_pkg::byte_t prg_pages;   // 16 KiB units
cart_load_pkg::byte_t chr_pages;   // 8 KiB units where 0 means CHR RAM
logic                 is_nes20;
logic                 tail_dirty;
logic                 is_dirty;
logic                 magic_ok;

// Smallest power of two page count that holds the image
function automatic cart_load_pkg::size_code_t size_class(input cart_load_pkg::byte_t pages);
	cart_load_pkg::size_code_t code;
	code = 3'd7;
	for (int i = 6; i >= 0; i--) begin
		if (pages <= (9'd1 << i))
			code = 3'(i);
	end
	return code;
endfunction

assign prg_pages = header[4];
assign chr_pages = header[5];

// NES 2.0 marks itself with 2'b10 in byte 7
assign is_nes20 = header[7][3:2] == 2'b10;

// Old dumps often carry junk in the tail
always_comb begin
	tail_dirty = |header[9][7:1];
	for (int i = 10; i < cart_load_pkg::HEADER_BYTES; i++)
		tail_dirty = tail_dirty | (|header[i]);
end

assign is_dirty = ~is_nes20 & tail_dirty;

assign magic_ok = {header[0], header[1], header[2], header[3]} == cart_load_pkg::INES_MAGIC;
assign header_ok = magic_ok & ~header[6][2];   // Trainer bit

assign prg_bytes = cart_load_pkg::byte_count_t'(prg_pages) << cart_load_pkg::PRG_PAGE_SHIFT;
assign chr_bytes = cart_load_pkg::byte_count_t'(chr_pages) << cart_load_pkg::CHR_PAGE_SHIFT;

always_comb begin
	flags.spare         = 1'b0;
	flags.piano         = is_nes20 && ({2'b00, header[15][5:0]} == cart_load_pkg::PIANO_EXPANSION);
	flags.prg_ram_shift = is_nes20 ? header[10][3:0] : 4'h0;   // 64 << shift
	flags.has_saves     = header[6][1];
	flags.submapper     = is_nes20 ? header[8] : 8'h00;
	flags.four_screen   = header[6][3];
	flags.has_chr_ram   = chr_pages == 8'h00;
	flags.mirroring     = header[6][0] ^ invert_mirroring;
	flags.chr_size      = size_class(chr_pages);
	flags.prg_size      = size_class(prg_pages);

	// Upper nibble is not trusted in a dirty header
	flags.mapper        = {is_dirty ? 4'h0 : header[7][7:4], header[6][7:4]};
end

endmodule

// ==== hdl/cart_load_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Types and constants shared by the iNES cartridge loader
// Cartridge memory is byte wide with a 22-bit address space
// The mapper flag layout is the one the NES core decodes
//////////////////////////////////////////////////////////////////////

package cart_load_pkg;

	// Widths with a meaning of their own
	typedef logic [7:0]  byte_t;
	typedef logic [21:0] mem_addr_t;
	typedef logic [21:0] byte_count_t;   // Bytes still to copy in a region
	typedef logic [2:0]  size_code_t;    // log2 size class
	typedef logic [1:0]  slot_phase_t;

	////////////////////////////////////////////////////////////////////
	// iNES header
	////////////////////////////////////////////////////////////////////

	localparam int HEADER_BYTES = 16;

	typedef logic [$clog2(HEADER_BYTES)-1:0] hdr_idx_t;

	localparam hdr_idx_t HDR_LAST = hdr_idx_t'(HEADER_BYTES - 1);

	localparam logic [31:0] INES_MAGIC = {8'h4E, 8'h45, 8'h53, 8'h1A};  // "NES" 0x1A

	localparam byte_t PIANO_EXPANSION = 8'h19;  // NES 2.0 expansion device

	localparam int PRG_PAGE_SHIFT = 14;  // 16 KiB pages
	localparam int CHR_PAGE_SHIFT = 13;  // 8 KiB pages

	////////////////////////////////////////////////////////////////////
	// Address map and timing
	////////////////////////////////////////////////////////////////////

	localparam mem_addr_t PRG_BASE = 22'h000000;
	localparam mem_addr_t CHR_BASE = 22'h200000;

	// Memory takes a write only in this phase of the 4-clock cycle
	localparam slot_phase_t SLOT_PHASE = 2'd3;

	localparam logic [7:0] HOLD_COUNT = 8'd255;  // Console hold after load

	// Flag word handed to the mapper logic with the top bit first
	typedef struct packed {
		logic       spare;
		logic       piano;
		logic [3:0] prg_ram_shift;
		logic       has_saves;
		logic [7:0] submapper;
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;
		size_code_t chr_size;
		size_code_t prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef enum logic [2:0] {
		S_HEADER,
		S_PRG,
		S_CHR,
		S_ERROR,
		S_DONE
	} load_state_t;

endpackage
